// File: Bender.yml
package:
  name: pc_check

sources:
  - files:
      - hdl/pc_check_pkg.sv
      - hdl/pc_ctrl_if.sv
      - hdl/pc_addr_check.sv
      - hdl/pc_decision_check.sv
      - hdl/pc_err_combine.sv
      - hdl/pc_check_top.sv
  - target: test
    files:
      - test/tb_pc_check.sv

// File: filelist.f
hdl/pc_check_pkg.sv
hdl/pc_ctrl_if.sv
hdl/pc_addr_check.sv
hdl/pc_decision_check.sv
hdl/pc_err_combine.sv
hdl/pc_check_top.sv
test/tb_pc_check.sv

// File: hdl/pc_addr_check.sv
// PC address recompute check

`timescale 1ns/100ps

module pc_addr_check (
  input  logic                                clk,
  input  logic                                rst_n,
  pc_ctrl_if.addr_mp                          ctrl,

  // Pipeline handshake into ID
  input  logic                                if_valid_i,
  input  logic                                id_ready_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     pc_if_i,

  // Instruction currently in ID
  input  logic [pc_check_pkg::ADDR_W-1:0]     id_pc_i,
  input  logic                                id_compressed_i,
  input  logic                                id_dummy_i,

  // Resolved control flow targets and CSR values
  input  logic [pc_check_pkg::ADDR_W-1:0]     jump_target_id_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     branch_target_ex_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     mepc_i,
  input  logic [pc_check_pkg::MTVEC_W-1:0]    mtvec_addr_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     dpc_i,

  // Static addresses from the core pins
  input  logic [pc_check_pkg::ADDR_W-1:0]     boot_addr_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     dm_halt_addr_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     dm_exception_addr_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     nmi_addr_i,

  output logic                                addr_err_o
);

  // Registered view of last cycle's PC update
  logic                                   pc_set_q;
  pc_check_pkg::pc_mux_e                  pc_mux_q;
  // IF to ID transfer seen last cycle
  logic                                   if_id_q;

  logic [pc_check_pkg::ADDR_W-1:0]        incr_addr;
  logic [pc_check_pkg::ADDR_W-1:0]        ctrl_flow_addr;
  logic [pc_check_pkg::ADDR_W-1:0]        check_addr;
  logic                                   recompute_ok;

  ////////////////////////////////////////////////////////////////////////////
  // Expected address
  ////////////////////////////////////////////////////////////////////////////

  // Sequential successor of the ID instruction, dummies do not advance
  assign incr_addr = id_pc_i + (id_dummy_i      ? '0                           :
                                id_compressed_i ? pc_check_pkg::STEP_COMPRESSED :
                                                  pc_check_pkg::STEP_FULL);

  // Target chosen from the stored select
  // A corrupted pc_mux_q lands on the wrong source and trips the compare
  always_comb begin
    case (pc_mux_q)
      pc_check_pkg::PC_JUMP:     ctrl_flow_addr = jump_target_id_i;
      pc_check_pkg::PC_MRET:     ctrl_flow_addr = mepc_i;
      pc_check_pkg::PC_BRANCH:   ctrl_flow_addr = branch_target_ex_i;
      pc_check_pkg::PC_TRAP_DBD: ctrl_flow_addr = dm_halt_addr_i;
      pc_check_pkg::PC_TRAP_DBE: ctrl_flow_addr = dm_exception_addr_i;
      pc_check_pkg::PC_TRAP_NMI: ctrl_flow_addr = nmi_addr_i;
      pc_check_pkg::PC_DRET:     ctrl_flow_addr = dpc_i;
      pc_check_pkg::PC_TRAP_EXC: begin
        // Vector base sits above the 128 byte alignment
        ctrl_flow_addr = {{pc_check_pkg::MTVEC_PAD{1'b0}}, mtvec_addr_i,
                          {pc_check_pkg::MTVEC_SHIFT{1'b0}}};
      end
      default: begin
        // Boot and any unlisted select, word aligned
        ctrl_flow_addr = {boot_addr_i[pc_check_pkg::ADDR_W-1:2], 2'b00};
      end
    endcase
  end

  // Control flow change wins over sequential fetch
  // Bit 0 tied low, fetch is halfword aligned with C support
  assign check_addr = pc_set_q ? {ctrl_flow_addr[pc_check_pkg::ADDR_W-1:1], 1'b0} :
                                 incr_addr;

  // Only the cycle after a PC set or an IF to ID move is checked
  assign recompute_ok = (check_addr == pc_if_i);
  assign addr_err_o   = (pc_set_q || if_id_q) && !recompute_ok;

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_set_q <= 1'b0;
      pc_mux_q <= pc_check_pkg::PC_BOOT;
      if_id_q  <= 1'b0;
    end else begin
      // WB+4 and IRQ targets cannot be rebuilt here, skip them
      pc_set_q <= ctrl.pc_set &&
                  (ctrl.pc_mux != pc_check_pkg::PC_WB_PLUS4) &&
                  (ctrl.pc_mux != pc_check_pkg::PC_TRAP_IRQ);
      if_id_q  <= if_valid_i && id_ready_i;
      // Select only captured on a real update
      if (ctrl.pc_set) begin
        pc_mux_q <= ctrl.pc_mux;
      end
    end
  end

endmodule

// File: hdl/pc_check_pkg.sv
// PC checker shared definitions

package pc_check_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Address geometry
  ////////////////////////////////////////////////////////////////////////////

  // Full fetch address width
  localparam int unsigned ADDR_W = 32;

  // Trap vector base field as delivered by the CSR file
  localparam int unsigned MTVEC_W = 24;

  // Vector base is aligned to 128 bytes
  localparam int unsigned MTVEC_SHIFT = 7;

  // Zero bits above the vector base to fill the full address
  localparam int unsigned MTVEC_PAD = ADDR_W - MTVEC_W - MTVEC_SHIFT;

  ////////////////////////////////////////////////////////////////////////////
  // Sequential increments
  ////////////////////////////////////////////////////////////////////////////

  // 16-bit instruction from the C extension
  localparam logic [ADDR_W-1:0] STEP_COMPRESSED = 32'd2;

  // Regular 32-bit instruction
  localparam logic [ADDR_W-1:0] STEP_FULL = 32'd4;

  ////////////////////////////////////////////////////////////////////////////
  // PC multiplexer select
  ////////////////////////////////////////////////////////////////////////////

  // Source of a non-sequential PC update, as driven by the controller
  typedef enum logic [3:0] {
    // Refetch of the instruction after the one in WB
    PC_WB_PLUS4 = 4'b0001,
    // Jump or jump-register target resolved in ID
    PC_JUMP     = 4'b0010,
    // Taken conditional branch resolved in EX
    PC_BRANCH   = 4'b0011,
    // Start of execution after reset
    PC_BOOT     = 4'b0100,
    // Return from machine trap
    PC_MRET     = 4'b0101,
    // Return from debug mode
    PC_DRET     = 4'b0110,
    // Synchronous exception through the trap vector
    PC_TRAP_EXC = 4'b1000,
    // Interrupt entry, target not recomputed here
    PC_TRAP_IRQ = 4'b1001,
    // Debug halt entry
    PC_TRAP_DBD = 4'b1010,
    // Exception taken while in debug mode
    PC_TRAP_DBE = 4'b1011,
    // Non-maskable interrupt entry
    PC_TRAP_NMI = 4'b1100
  } pc_mux_e;

endpackage

// File: hdl/pc_check_top.sv
// PC hardening checker top

`timescale 1ns/100ps

module pc_check_top (
  input  logic                                clk,
  input  logic                                rst_n,

  // Pipeline handshakes
  input  logic                                if_valid_i,
  input  logic                                id_ready_i,
  input  logic                                id_valid_i,
  input  logic                                ex_ready_i,
  input  logic                                ex_valid_i,
  input  logic                                wb_ready_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     pc_if_i,

  // Controller
  input  logic                                pc_set_i,
  input  pc_check_pkg::pc_mux_e               pc_mux_i,
  input  logic                                kill_id_i,
  input  logic                                kill_ex_i,
  input  logic                                jump_in_id_i,
  input  logic                                branch_in_ex_i,

  // Stage contents
  input  logic [pc_check_pkg::ADDR_W-1:0]     id_pc_i,
  input  logic                                id_compressed_i,
  input  logic                                id_dummy_i,
  input  logic                                id_instr_valid_i,
  input  logic                                ex_instr_valid_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     jump_target_id_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     branch_target_ex_i,
  input  logic                                branch_decision_ex_i,
  input  logic                                last_op_id_i,
  input  logic                                last_op_ex_i,

  // CSRs
  input  logic [pc_check_pkg::ADDR_W-1:0]     mepc_i,
  input  logic [pc_check_pkg::MTVEC_W-1:0]    mtvec_addr_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     dpc_i,

  // Static pin addresses
  input  logic [pc_check_pkg::ADDR_W-1:0]     boot_addr_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     dm_halt_addr_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     dm_exception_addr_i,
  input  logic [pc_check_pkg::ADDR_W-1:0]     nmi_addr_i,

  output logic                                pc_err_o,
  output logic                                pc_fault_o
);

  logic addr_err;
  logic flow_err;

  // Controller bundle shared by both checkers
  pc_ctrl_if ctrl_if ();

  assign ctrl_if.pc_set       = pc_set_i;
  assign ctrl_if.pc_mux       = pc_mux_i;
  assign ctrl_if.kill_id      = kill_id_i;
  assign ctrl_if.kill_ex      = kill_ex_i;
  assign ctrl_if.jump_in_id   = jump_in_id_i;
  assign ctrl_if.branch_in_ex = branch_in_ex_i;

  ////////////////////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////////////////////

  pc_addr_check pc_addr_check_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl                (ctrl_if.addr_mp),
    .if_valid_i          (if_valid_i),
    .id_ready_i          (id_ready_i),
    .pc_if_i             (pc_if_i),
    .id_pc_i             (id_pc_i),
    .id_compressed_i     (id_compressed_i),
    .id_dummy_i          (id_dummy_i),
    .jump_target_id_i    (jump_target_id_i),
    .branch_target_ex_i  (branch_target_ex_i),
    .mepc_i              (mepc_i),
    .mtvec_addr_i        (mtvec_addr_i),
    .dpc_i               (dpc_i),
    .boot_addr_i         (boot_addr_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .nmi_addr_i          (nmi_addr_i),
    .addr_err_o          (addr_err)
  );

  pc_decision_check pc_decision_check_inst (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl                 (ctrl_if.dec_mp),
    .id_valid_i           (id_valid_i),
    .ex_ready_i           (ex_ready_i),
    .ex_valid_i           (ex_valid_i),
    .wb_ready_i           (wb_ready_i),
    .id_instr_valid_i     (id_instr_valid_i),
    .ex_instr_valid_i     (ex_instr_valid_i),
    .last_op_id_i         (last_op_id_i),
    .last_op_ex_i         (last_op_ex_i),
    .branch_decision_ex_i (branch_decision_ex_i),
    .flow_err_o           (flow_err)
  );

  // Gate and latch
  pc_err_combine pc_err_combine_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_set_i   (pc_set_i),
    .addr_err_i (addr_err),
    .flow_err_i (flow_err),
    .pc_err_o   (pc_err_o),
    .pc_fault_o (pc_fault_o)
  );

endmodule

// File: hdl/pc_ctrl_if.sv
// Controller PC update bundle

`timescale 1ns/100ps

interface pc_ctrl_if;

  // One-cycle strobe, a new PC is being set
  logic                   pc_set;
  // Source of the new PC, valid with pc_set
  pc_check_pkg::pc_mux_e  pc_mux;
  // Flush of the ID stage
  logic                   kill_id;
  // Flush of the EX stage
  logic                   kill_ex;
  // Jump or mret present in ID, unqualified by halt or kill
  logic                   jump_in_id;
  // Branch present in EX, unqualified by halt or kill
  logic                   branch_in_ex;

  // Address checker only cares about the PC update itself
  modport addr_mp (
    input pc_set,
    input pc_mux
  );

  // Decision checker also follows the stage contents
  modport dec_mp (
    input pc_set,
    input pc_mux,
    input kill_id,
    input kill_ex,
    input jump_in_id,
    input branch_in_ex
  );

endinterface

// File: hdl/pc_decision_check.sv
// Jump and branch decision check

`timescale 1ns/100ps

module pc_decision_check (
  input  logic        clk,
  input  logic        rst_n,
  pc_ctrl_if.dec_mp   ctrl,

  // Stage handshakes
  input  logic        id_valid_i,
  input  logic        ex_ready_i,
  input  logic        ex_valid_i,
  input  logic        wb_ready_i,

  // Registered instruction valids of ID and EX
  input  logic        id_instr_valid_i,
  input  logic        ex_instr_valid_i,

  // Last operation of a split instruction
  input  logic        last_op_id_i,
  input  logic        last_op_ex_i,

  // Branch condition outcome in EX
  input  logic        branch_decision_ex_i,

  output logic        flow_err_o
);

  // Taken flags, held until the instruction leaves its stage
  logic jmp_taken_q;
  logic bch_taken_q;

  // Stage completion and flush
  logic id_done;
  logic ex_done;

  // Controller decision for this cycle
  logic jump_set;
  logic branch_set;

  // Individual disagreements
  logic jump_taken_err;
  logic jump_untaken_err;
  logic branch_taken_err;
  logic branch_untaken_err;

  assign id_done = id_valid_i && ex_ready_i && last_op_id_i;
  assign ex_done = ex_valid_i && wb_ready_i && last_op_ex_i;

  // mret is redirected from ID just like a jump
  assign jump_set   = ctrl.pc_set && ((ctrl.pc_mux == pc_check_pkg::PC_JUMP) ||
                                      (ctrl.pc_mux == pc_check_pkg::PC_MRET));
  assign branch_set = ctrl.pc_set && (ctrl.pc_mux == pc_check_pkg::PC_BRANCH);

  ////////////////////////////////////////////////////////////////////////////
  // Taken flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      jmp_taken_q <= 1'b0;
      bch_taken_q <= 1'b0;
    end else begin
      // Clear on ID completion or flush, clear beats set
      if (id_done || ctrl.kill_id) begin
        jmp_taken_q <= 1'b0;
      end else if (jump_set) begin
        jmp_taken_q <= 1'b1;
      end
      // Same scheme one stage later
      if (ex_done || ctrl.kill_ex) begin
        bch_taken_q <= 1'b0;
      end else if (branch_set) begin
        bch_taken_q <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flow errors
  ////////////////////////////////////////////////////////////////////////////

  // Flag set but the instruction that caused it is gone
  assign jump_taken_err   = jmp_taken_q && !ctrl.jump_in_id;
  assign branch_taken_err = bch_taken_q && !(ctrl.branch_in_ex && branch_decision_ex_i);

  // Last op of a live jump or taken branch, yet nothing was taken
  // Instr valid excludes ones killed earlier
  assign jump_untaken_err   = !jmp_taken_q && ctrl.jump_in_id &&
                              id_instr_valid_i && last_op_id_i;
  assign branch_untaken_err = !bch_taken_q && ctrl.branch_in_ex &&
                              ex_instr_valid_i && last_op_ex_i && branch_decision_ex_i;

  assign flow_err_o = jump_taken_err || branch_taken_err ||
                      jump_untaken_err || branch_untaken_err;

endmodule

// File: hdl/pc_err_combine.sv
// PC check error merge and fault latch

`timescale 1ns/100ps

module pc_err_combine (
  input  logic clk,
  input  logic rst_n,

  // First PC set arms the checker
  input  logic pc_set_i,

  // Raw error sources
  input  logic addr_err_i,
  input  logic flow_err_i,

  output logic pc_err_o,
  output logic pc_fault_o
);

  // Sticky arm bit, nothing is trusted before the boot PC set
  logic compare_en_q;
  // Sticky fault for escalation
  logic fault_q;

  // Either source counts once armed
  assign pc_err_o = (addr_err_i || flow_err_i) && compare_en_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      compare_en_q <= 1'b0;
      fault_q      <= 1'b0;
    end else begin
      if (pc_set_i) begin
        compare_en_q <= 1'b1;
      end
      // Held until reset
      if (pc_err_o) begin
        fault_q <= 1'b1;
      end
    end
  end

  assign pc_fault_o = fault_q;

endmodule

// File: test/tb_pc_check.sv
// PC checker random testbench

`timescale 1ns/100ps

module tb_pc_check;

  // Clock period in ns and reset length in cycles
  localparam int CLK_PERIOD = 4;
  localparam int N_RESET    = 5;

  // Test lengths in cycles
  localparam int N_QUIET = 40;
  localparam int N_MUX   = 120;
  localparam int N_SEQ   = 120;
  localparam int N_DEC   = 120;
  localparam int N_RAND  = 160;
  localparam int TOTAL_CYCLES = N_QUIET + N_MUX + N_SEQ + N_DEC + N_RAND + 3 * (N_RESET + 1);

  logic clk;
  logic rst_n;
  logic if_valid, id_ready, id_valid, ex_ready, ex_valid, wb_ready;
  logic pc_set, kill_id, kill_ex, jump_in_id, branch_in_ex;
  logic id_compressed, id_dummy, id_instr_valid, ex_instr_valid;
  logic branch_decision, last_op_id, last_op_ex;
  logic [31:0] pc_if, id_pc, jump_target, branch_target, mepc, dpc;
  logic [31:0] boot_addr, dm_halt_addr, dm_exception_addr, nmi_addr;
  logic [23:0] mtvec_addr;
  pc_check_pkg::pc_mux_e pc_mux;
  logic pc_err;
  logic pc_fault;

  // Cycle model state mirroring the registered view of the checker
  logic m_set_q, m_ifid_q, m_jmp, m_bch, m_cmp_en, m_fault;
  pc_check_pkg::pc_mux_e m_mux;

  logic [31:0] lfsr;
  int          errors;
  int          checks;

  pc_check_top pc_check_top_inst (
    .clk (clk), .rst_n (rst_n),
    .if_valid_i (if_valid), .id_ready_i (id_ready), .id_valid_i (id_valid),
    .ex_ready_i (ex_ready), .ex_valid_i (ex_valid), .wb_ready_i (wb_ready),
    .pc_if_i (pc_if), .pc_set_i (pc_set), .pc_mux_i (pc_mux),
    .kill_id_i (kill_id), .kill_ex_i (kill_ex),
    .jump_in_id_i (jump_in_id), .branch_in_ex_i (branch_in_ex),
    .id_pc_i (id_pc), .id_compressed_i (id_compressed), .id_dummy_i (id_dummy),
    .id_instr_valid_i (id_instr_valid), .ex_instr_valid_i (ex_instr_valid),
    .jump_target_id_i (jump_target), .branch_target_ex_i (branch_target),
    .branch_decision_ex_i (branch_decision),
    .last_op_id_i (last_op_id), .last_op_ex_i (last_op_ex),
    .mepc_i (mepc), .mtvec_addr_i (mtvec_addr), .dpc_i (dpc),
    .boot_addr_i (boot_addr), .dm_halt_addr_i (dm_halt_addr),
    .dm_exception_addr_i (dm_exception_addr), .nmi_addr_i (nmi_addr),
    .pc_err_o (pc_err), .pc_fault_o (pc_fault)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic rand_bit();
    return rand_bits(1) != 0;
  endfunction

  // Roughly pct percent true
  function automatic logic chance(input int pct);
    return (rand_bits(7) % 100) < pct;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  // Fetch address the IF stage should hold this cycle
  function automatic logic [31:0] expected_pc();
    logic [31:0] target;
    logic [31:0] step;
    if (id_dummy) begin
      step = 32'd0;
    end else if (id_compressed) begin
      step = pc_check_pkg::STEP_COMPRESSED;
    end else begin
      step = pc_check_pkg::STEP_FULL;
    end
    case (m_mux)
      pc_check_pkg::PC_JUMP:     target = jump_target;
      pc_check_pkg::PC_MRET:     target = mepc;
      pc_check_pkg::PC_BRANCH:   target = branch_target;
      pc_check_pkg::PC_TRAP_DBD: target = dm_halt_addr;
      pc_check_pkg::PC_TRAP_DBE: target = dm_exception_addr;
      pc_check_pkg::PC_TRAP_NMI: target = nmi_addr;
      pc_check_pkg::PC_DRET:     target = dpc;
      pc_check_pkg::PC_TRAP_EXC: target = {8'h00, mtvec_addr} << pc_check_pkg::MTVEC_SHIFT;
      default:                   target = boot_addr & 32'hffff_fffc;
    endcase
    if (m_set_q) begin
      return target & 32'hffff_fffe;
    end
    return id_pc + step;
  endfunction

  // Jump and branch disagreement for the current inputs
  function automatic logic expected_flow();
    logic branch_now;
    branch_now = branch_in_ex && branch_decision;
    if (m_jmp && !jump_in_id) return 1'b1;
    if (m_bch && !branch_now) return 1'b1;
    if (!m_jmp && jump_in_id && id_instr_valid && last_op_id) return 1'b1;
    if (!m_bch && branch_now && ex_instr_valid && last_op_ex) return 1'b1;
    return 1'b0;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and model update
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_inputs();
    {if_valid, id_ready, id_valid, ex_ready, ex_valid, wb_ready} = '0;
    {pc_set, kill_id, kill_ex, jump_in_id, branch_in_ex} = '0;
    {id_compressed, id_dummy, id_instr_valid, ex_instr_valid} = '0;
    {branch_decision, last_op_id, last_op_ex} = '0;
    {pc_if, id_pc, jump_target, branch_target, mepc, dpc} = '0;
    {boot_addr, dm_halt_addr, dm_exception_addr, nmi_addr} = '0;
    mtvec_addr = '0;
    pc_mux     = pc_check_pkg::PC_BOOT;
  endtask

  task automatic reset_model();
    {m_set_q, m_ifid_q, m_jmp, m_bch, m_cmp_en, m_fault} = '0;
    m_mux = pc_check_pkg::PC_BOOT;
  endtask

  // Idle inputs keep the first edge after release a no-op
  task automatic do_reset();
    @(negedge clk);
    rst_n = 1'b0;
    idle_inputs();
    repeat (N_RESET) @(negedge clk);
    rst_n = 1'b1;
    reset_model();
  endtask

  task automatic drive_inputs(input int set_pct, input int addr_pct, input int flow_pct);
    logic [31:0] tmp;
    tmp = rand_bits(4);
    {if_valid, id_ready, id_valid, ex_ready} = tmp[3:0];
    tmp = rand_bits(4);
    {ex_valid, wb_ready, last_op_id, last_op_ex} = tmp[3:0];
    tmp = rand_bits(4);
    {id_compressed, id_dummy, id_instr_valid, ex_instr_valid} = tmp[3:0];
    pc_set  = chance(set_pct);
    tmp     = rand_bits(4);
    pc_mux  = pc_check_pkg::pc_mux_e'(tmp[3:0]);
    kill_id = chance(10);
    kill_ex = chance(10);
    id_pc             = rand_bits(32);
    jump_target       = rand_bits(32);
    branch_target     = rand_bits(32);
    mepc              = rand_bits(32);
    dpc               = rand_bits(32);
    boot_addr         = rand_bits(32);
    dm_halt_addr      = rand_bits(32);
    dm_exception_addr = rand_bits(32);
    nmi_addr          = rand_bits(32);
    tmp        = rand_bits(24);
    mtvec_addr = tmp[23:0];
    // Clean stage contents follow the taken flags
    jump_in_id      = m_jmp;
    branch_in_ex    = m_bch;
    branch_decision = m_bch || rand_bit();
    if (chance(flow_pct)) begin
      if (rand_bit()) begin
        jump_in_id = !jump_in_id;
      end else begin
        branch_in_ex    = !branch_in_ex;
        branch_decision = rand_bit();
      end
    end
    // Correct fetch address when armed and anything otherwise
    pc_if = (m_set_q || m_ifid_q) ? expected_pc() : rand_bits(32);
    if (chance(addr_pct)) begin
      pc_if = pc_if ^ (32'h2 << (rand_bits(5) % 31));
    end
  endtask

  // State as it stands after the coming rising edge
  task automatic update_model(input logic exp_err);
    if ((id_valid && ex_ready && last_op_id) || kill_id) begin
      m_jmp = 1'b0;
    end else if (pc_set && (pc_mux == pc_check_pkg::PC_JUMP ||
                            pc_mux == pc_check_pkg::PC_MRET)) begin
      m_jmp = 1'b1;
    end
    if ((ex_valid && wb_ready && last_op_ex) || kill_ex) begin
      m_bch = 1'b0;
    end else if (pc_set && pc_mux == pc_check_pkg::PC_BRANCH) begin
      m_bch = 1'b1;
    end
    m_set_q  = pc_set && (pc_mux != pc_check_pkg::PC_WB_PLUS4) &&
               (pc_mux != pc_check_pkg::PC_TRAP_IRQ);
    m_ifid_q = if_valid && id_ready;
    if (pc_set) begin
      m_mux    = pc_mux;
      m_cmp_en = 1'b1;
    end
    if (exp_err) begin
      m_fault = 1'b1;
    end
  endtask

  task automatic run_test(input string name, input int cycles, input int set_pct,
                          input int addr_pct, input int flow_pct);
    int   start_errors;
    logic exp_addr_err;
    logic exp_err;
    start_errors = errors;
    repeat (cycles) begin
      @(negedge clk);
      drive_inputs(set_pct, addr_pct, flow_pct);
      // Sample well before the rising edge
      #1;
      exp_addr_err = (m_set_q || m_ifid_q) && (pc_if !== expected_pc());
      exp_err      = m_cmp_en && (exp_addr_err || expected_flow());
      check_val("pc_err_o", pc_err, exp_err);
      check_val("pc_fault_o", pc_fault, m_fault);
      update_model(exp_err);
    end
    $display("Test %s: %0d cycles, %0d mismatches", name, cycles, errors - start_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lfsr   = 32'h532b4ddc;
    errors = 0;
    checks = 0;
    rst_n  = 1'b0;
    idle_inputs();
    reset_model();
    do_reset();
    // Nothing counts before the first PC set
    run_test("reset_quiet", N_QUIET, 0, 50, 50);
    run_test("pc_mux_clean", N_MUX, 40, 0, 0);
    run_test("sequential", N_SEQ, 5, 15, 0);
    do_reset();
    run_test("decisions", N_DEC, 30, 0, 15);
    do_reset();
    // Fault goes sticky somewhere in here
    run_test("random_traffic", N_RAND, 25, 10, 10);
    $display("Checks %0d, mismatches %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Twice the expected run length
  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("Watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
